// ==== mc_config.svh ====
`ifndef MC_CONFIG_SVH
`define MC_CONFIG_SVH

// sample and block geometry
`define MC_PIX_W    8
`define MC_BLK_PIX  16

// quantized residual width, wide enough for a 9 bit signed residual
`define MC_COEF_W   10

// eighth-pel motion fraction
`define MC_FRAC_W   3

// right shift applied by the quantizer, 0..7
`define MC_QSH_W    3

`endif

// ==== mc_pixel_pkg.sv ====
`default_nettype none

`include "mc_config.svh"

package mc_pixel_pkg;

    // one unsigned sample
    typedef logic [`MC_PIX_W-1:0] pixel_t;

    // orig - pred, one bit wider than a sample
    typedef logic signed [`MC_PIX_W:0] resid_t;

    // quantized residual
    typedef logic signed [`MC_COEF_W-1:0] coef_t;

    // pixel position inside a 4x4 block
    typedef logic [$clog2(`MC_BLK_PIX)-1:0] pix_idx_t;

    // raster order, element 0 is top-left
    typedef pixel_t [`MC_BLK_PIX-1:0] blk4x4_t;

    // reference window indexed [y][x], one extra row and column for the
    // bilinear neighbours
    typedef pixel_t [4:0][4:0] chroma_win_t;

endpackage

`default_nettype wire

// ==== mc_ctrl_pkg.sv ====
`default_nettype none

`include "mc_config.svh"

package mc_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        TQ_LUMA = 3'd1,
        MC_CB   = 3'd2,
        TQ_CB   = 3'd3,
        MC_CR   = 3'd4,
        TQ_CR   = 3'd5,
        DONE    = 3'd6
    } mc_state_e;

    typedef logic [1:0] tq_sel_t;     // component tag on tq and coefficients

    localparam tq_sel_t TQ_SEL_LUMA = 2'b00;
    localparam tq_sel_t TQ_SEL_CB   = 2'b10;
    localparam tq_sel_t TQ_SEL_CR   = 2'b11;

    typedef logic [`MC_FRAC_W-1:0] frac_t;

    typedef struct packed {
        frac_t dx;
        frac_t dy;
    } mv_frac_t;

    typedef struct packed {
        tq_sel_t                comp;
        mc_pixel_pkg::pix_idx_t idx;
        mc_pixel_pkg::coef_t    value;
    } coef_out_t;

endpackage

`default_nettype wire

// ==== mc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mc_ctrl (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             mc_start_i,
    input  wire logic             tq_done_i,
    input  wire logic             chroma_done_i,
    output logic                  mc_done_o,
    output logic                  mvd_access_o,
    output logic                  tq_start_o,
    output mc_ctrl_pkg::tq_sel_t  tq_sel_o,
    output logic                  chroma_start_o,
    output logic                  chroma_sel_o
);

    import mc_ctrl_pkg::*;

    mc_state_e state;
    mc_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (mc_start_i)
                    next_state = TQ_LUMA;
            end
            TQ_LUMA: begin
                if (tq_done_i)
                    next_state = MC_CB;
            end
            MC_CB: begin
                if (chroma_done_i)
                    next_state = TQ_CB;
            end
            TQ_CB: begin
                if (tq_done_i)
                    next_state = MC_CR;
            end
            MC_CR: begin
                if (chroma_done_i)
                    next_state = TQ_CR;
            end
            TQ_CR: begin
                if (tq_done_i)
                    next_state = DONE;
            end
            DONE:    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= IDLE;
        else
            state <= next_state;
    end

    assign mc_done_o    = (state == DONE);
    assign mvd_access_o = (state == TQ_LUMA);   // mv fraction may be updated here

    assign tq_start_o = (state == IDLE  && next_state == TQ_LUMA) ||
                        (state == MC_CB && next_state == TQ_CB)   ||
                        (state == MC_CR && next_state == TQ_CR);

    assign chroma_start_o = (state == TQ_LUMA && next_state == MC_CB) ||
                            (state == TQ_CB   && next_state == MC_CR);

    // the selects already point at the next component in the cycle that
    // starts it, since the units sample their operands on the start pulse
    always_comb begin
        case (state)
            MC_CB, TQ_CB: tq_sel_o = TQ_SEL_CB;
            MC_CR, TQ_CR: tq_sel_o = TQ_SEL_CR;
            default:      tq_sel_o = TQ_SEL_LUMA;
        endcase
    end

    assign chroma_sel_o = (state == TQ_CB) || (state == MC_CR);   // 1 = Cr

    a_start_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(tq_start_o && chroma_start_o))
        else $error("tq and chroma started in the same cycle");

    // a stray done from tq_unit would skip a phase
    a_tq_done_phase: assert property (@(posedge clk) disable iff (!rstn)
        tq_done_i |-> (state inside {TQ_LUMA, TQ_CB, TQ_CR}))
        else $error("tq_done outside a tq phase, state %0d", state);

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state inside {IDLE, TQ_LUMA, MC_CB, TQ_CB, MC_CR, TQ_CR, DONE})
        else $error("illegal state encoding %0d", state);

endmodule

`default_nettype wire

// ==== chroma_interp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_config.svh"

module chroma_interp (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       start_i,
    input  wire mc_pixel_pkg::chroma_win_t  win_i,
    input  wire mc_ctrl_pkg::mv_frac_t      frac_i,
    output mc_pixel_pkg::blk4x4_t           pred_o,
    output logic                            done_o
);

    import mc_pixel_pkg::*;
    import mc_ctrl_pkg::*;

    localparam int       ACC_W    = `MC_PIX_W + 6;   // weights sum to 64
    localparam pix_idx_t LAST_IDX = pix_idx_t'(`MC_BLK_PIX - 1);

    chroma_win_t       win_q;
    mv_frac_t          frac_q;
    chroma_win_t       win_use;
    mv_frac_t          frac_use;
    logic              busy;
    logic              run;
    pix_idx_t          cnt;
    logic [2:0]        x0;
    logic [2:0]        x1;
    logic [2:0]        y0;
    logic [2:0]        y1;
    logic [3:0]        fx0;
    logic [3:0]        fx1;
    logic [3:0]        fy0;
    logic [3:0]        fy1;
    logic [6:0]        wa;
    logic [6:0]        wb;
    logic [6:0]        wc;
    logic [6:0]        wd;
    logic [ACC_W-1:0]  acc;
    pixel_t            pix;

    assign run = start_i | busy;

    // pixel 0 is computed in the start cycle straight from the inputs
    assign win_use  = start_i ? win_i  : win_q;
    assign frac_use = start_i ? frac_i : frac_q;

    always_comb begin
        x0  = {1'b0, cnt[1:0]};
        y0  = {1'b0, cnt[3:2]};
        x1  = x0 + 3'd1;
        y1  = y0 + 3'd1;
        fx1 = {1'b0, frac_use.dx};
        fy1 = {1'b0, frac_use.dy};
        fx0 = 4'd8 - fx1;
        fy0 = 4'd8 - fy1;
        wa  = 7'(fx0 * fy0);
        wb  = 7'(fx1 * fy0);
        wc  = 7'(fx0 * fy1);
        wd  = 7'(fx1 * fy1);
        acc = wa * win_use[y0][x0] + wb * win_use[y0][x1] +
              wc * win_use[y1][x0] + wd * win_use[y1][x1] + ACC_W'(32);
        pix = acc[ACC_W-1:6];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= run && (cnt == LAST_IDX);   // 16th pixel visible now
            if (run) begin
                cnt  <= cnt + 1'b1;
                busy <= (cnt != LAST_IDX);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            win_q  <= win_i;
            frac_q <= frac_i;
        end
        if (run)
            pred_o[cnt] <= pix;
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rstn)
        start_i |-> !busy)
        else $error("chroma start while interpolating");

endmodule

`default_nettype wire

// ==== tq_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_config.svh"

module tq_unit (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   start_i,
    input  wire mc_ctrl_pkg::tq_sel_t   sel_i,
    input  wire mc_pixel_pkg::blk4x4_t  pred_i,
    input  wire mc_pixel_pkg::blk4x4_t  orig_i,
    input  wire logic [`MC_QSH_W-1:0]   qshift_i,
    output logic                        coef_valid_o,
    output mc_ctrl_pkg::coef_out_t      coef_o,
    output logic                        done_o
);

    import mc_pixel_pkg::*;
    import mc_ctrl_pkg::*;

    localparam int RES_W = $bits(resid_t);
    localparam int EXT_W = (RES_W > `MC_COEF_W) ? RES_W : `MC_COEF_W;
    localparam logic signed [EXT_W-1:0] COEF_MAX = 2 ** (`MC_COEF_W - 1) - 1;
    localparam logic signed [EXT_W-1:0] COEF_MIN = -(2 ** (`MC_COEF_W - 1));
    localparam pix_idx_t LAST_IDX = pix_idx_t'(`MC_BLK_PIX - 1);

    blk4x4_t                  pred_q;
    blk4x4_t                  orig_q;
    logic [`MC_QSH_W-1:0]     qsh_q;
    tq_sel_t                  sel_q;
    blk4x4_t                  pred_use;
    blk4x4_t                  orig_use;
    logic [`MC_QSH_W-1:0]     qsh_use;
    tq_sel_t                  sel_use;
    logic                     busy;
    logic                     run;
    pix_idx_t                 idx;
    resid_t                   resid;
    logic signed [EXT_W-1:0]  shifted;
    coef_t                    coef;

    assign run = start_i | busy;

    // coefficient 0 comes from the live inputs in the start cycle
    assign pred_use = start_i ? pred_i   : pred_q;
    assign orig_use = start_i ? orig_i   : orig_q;
    assign qsh_use  = start_i ? qshift_i : qsh_q;
    assign sel_use  = start_i ? sel_i    : sel_q;

    always_comb begin
        resid   = $signed({1'b0, orig_use[idx]}) - $signed({1'b0, pred_use[idx]});
        shifted = EXT_W'(resid) >>> qsh_use;   // arithmetic, rounds toward -inf
        if (shifted > COEF_MAX)
            coef = coef_t'(COEF_MAX);
        else if (shifted < COEF_MIN)
            coef = coef_t'(COEF_MIN);
        else
            coef = coef_t'(shifted);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy         <= 1'b0;
            idx          <= '0;
            coef_valid_o <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            coef_valid_o <= run;
            done_o       <= run && (idx == LAST_IDX);
            if (run) begin
                idx  <= idx + 1'b1;
                busy <= (idx != LAST_IDX);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            pred_q <= pred_i;
            orig_q <= orig_i;
            qsh_q  <= qshift_i;
            sel_q  <= sel_i;
        end
        if (run) begin
            coef_o.comp  <= sel_use;
            coef_o.idx   <= idx;
            coef_o.value <= coef;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rstn)
        start_i |-> !busy)
        else $error("tq start while a block is in flight");

    // burst ends with done, nothing trails it
    a_quiet_after_done: assert property (@(posedge clk) disable iff (!rstn)
        (done_o && !start_i) |=> !coef_valid_o)
        else $error("coefficient valid after done without a new start");

endmodule

`default_nettype wire

// ==== mc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_config.svh"

module mc_top (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       mc_start_i,
    input  wire mc_pixel_pkg::blk4x4_t      luma_pred_i,
    input  wire mc_pixel_pkg::blk4x4_t      luma_orig_i,
    input  wire mc_pixel_pkg::blk4x4_t      cb_orig_i,
    input  wire mc_pixel_pkg::blk4x4_t      cr_orig_i,
    input  wire mc_pixel_pkg::chroma_win_t  cb_win_i,
    input  wire mc_pixel_pkg::chroma_win_t  cr_win_i,
    input  wire mc_ctrl_pkg::mv_frac_t      mv_frac_i,
    input  wire logic [`MC_QSH_W-1:0]       qshift_i,
    output logic                            mc_done_o,
    output logic                            mvd_access_o,
    output logic                            coef_valid_o,
    output mc_ctrl_pkg::coef_out_t          coef_o
);

    import mc_pixel_pkg::*;
    import mc_ctrl_pkg::*;

    logic         tq_start;
    tq_sel_t      tq_sel;
    logic         tq_done;
    logic         chroma_start;
    logic         chroma_sel;
    logic         chroma_done;
    blk4x4_t      chroma_pred;
    blk4x4_t      tq_pred;
    blk4x4_t      tq_orig;
    chroma_win_t  chroma_win;

    mc_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .mc_start_i     (mc_start_i),
        .tq_done_i      (tq_done),
        .chroma_done_i  (chroma_done),
        .mc_done_o      (mc_done_o),
        .mvd_access_o   (mvd_access_o),
        .tq_start_o     (tq_start),
        .tq_sel_o       (tq_sel),
        .chroma_start_o (chroma_start),
        .chroma_sel_o   (chroma_sel)
    );

    assign chroma_win = chroma_sel ? cr_win_i : cb_win_i;

    chroma_interp u_interp (
        .clk     (clk),
        .rstn    (rstn),
        .start_i (chroma_start),
        .win_i   (chroma_win),
        .frac_i  (mv_frac_i),
        .pred_o  (chroma_pred),
        .done_o  (chroma_done)
    );

    // luma prediction arrives ready-made, chroma comes from the interpolator
    assign tq_pred = (tq_sel == TQ_SEL_LUMA) ? luma_pred_i : chroma_pred;

    always_comb begin
        case (tq_sel)
            TQ_SEL_CB: tq_orig = cb_orig_i;
            TQ_SEL_CR: tq_orig = cr_orig_i;
            default:   tq_orig = luma_orig_i;
        endcase
    end

    tq_unit u_tq (
        .clk          (clk),
        .rstn         (rstn),
        .start_i      (tq_start),
        .sel_i        (tq_sel),
        .pred_i       (tq_pred),
        .orig_i       (tq_orig),
        .qshift_i     (qshift_i),
        .coef_valid_o (coef_valid_o),
        .coef_o       (coef_o),
        .done_o       (tq_done)
    );

endmodule

`default_nettype wire

// ==== tb_mc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_config.svh"

module tb_mc_top;

    import mc_pixel_pkg::*;
    import mc_ctrl_pkg::*;

    localparam int N_TESTS = 6;
    localparam int RUN_CYC = 81;                    // start to done
    localparam int N_COEF  = 3 * `MC_BLK_PIX;
    localparam int MAX_CYC = N_TESTS * (RUN_CYC + 10) + 50;

    localparam logic [1:0] COMP_LUMA = 2'b00;
    localparam logic [1:0] COMP_CB   = 2'b10;
    localparam logic [1:0] COMP_CR   = 2'b11;

    logic                  clk = 1'b0;
    logic                  rstn = 1'b0;
    logic                  mc_start = 1'b0;
    blk4x4_t               luma_pred = '0;
    blk4x4_t               luma_orig = '0;
    blk4x4_t               cb_orig = '0;
    blk4x4_t               cr_orig = '0;
    chroma_win_t           cb_win = '0;
    chroma_win_t           cr_win = '0;
    mv_frac_t              mv_frac = '0;
    logic [`MC_QSH_W-1:0]  qshift = '0;
    logic                  mc_done;
    logic                  mvd_access;
    logic                  coef_valid;
    coef_out_t             coef;

    logic [31:0]  lfsr = 32'h01c5_c72f;
    coef_out_t    exp_coef [N_COEF];
    coef_out_t    exp_now;
    logic         started = 1'b0;
    logic         run_active = 1'b0;
    int           run_cyc = 0;                      // cycle number inside a run
    int           coef_cnt = 0;
    int           cycle_cnt = 0;
    int           errors = 0;
    int           tests_failed = 0;

    mc_top mc_top_i (
        .clk          (clk),
        .rstn         (rstn),
        .mc_start_i   (mc_start),
        .luma_pred_i  (luma_pred),
        .luma_orig_i  (luma_orig),
        .cb_orig_i    (cb_orig),
        .cr_orig_i    (cr_orig),
        .cb_win_i     (cb_win),
        .cr_win_i     (cr_win),
        .mv_frac_i    (mv_frac),
        .qshift_i     (qshift),
        .mc_done_o    (mc_done),
        .mvd_access_o (mvd_access),
        .coef_valid_o (coef_valid),
        .coef_o       (coef)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_block(output blk4x4_t b);
        logic [31:0] v;
        for (int i = 0; i < `MC_BLK_PIX; i++) begin
            take_bits(`MC_PIX_W, v);
            b[i] = v[`MC_PIX_W-1:0];
        end
    endtask

    task automatic rand_window(output chroma_win_t w);
        logic [31:0] v;
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                take_bits(`MC_PIX_W, v);
                w[y][x] = v[`MC_PIX_W-1:0];
            end
        end
    endtask

    // (orig - pred) >>> qshift, clipped to the coefficient range
    function automatic coef_t quantize(input pixel_t orig, input pixel_t pred, input int qsh);
        int r;
        r = (int'(orig) - int'(pred)) >>> qsh;
        if (r > 2 ** (`MC_COEF_W - 1) - 1)
            r = 2 ** (`MC_COEF_W - 1) - 1;
        else if (r < -(2 ** (`MC_COEF_W - 1)))
            r = -(2 ** (`MC_COEF_W - 1));
        return coef_t'(r);
    endfunction

    function automatic pixel_t bilinear(input chroma_win_t w, input mv_frac_t f,
                                        input int x, input int y);
        int dx;
        int dy;
        int acc;
        dx  = int'(f.dx);
        dy  = int'(f.dy);
        acc = (8 - dx) * (8 - dy) * int'(w[y][x]) + dx * (8 - dy) * int'(w[y][x + 1])
            + (8 - dx) * dy * int'(w[y + 1][x]) + dx * dy * int'(w[y + 1][x + 1]) + 32;
        return pixel_t'(acc >> 6);
    endfunction

    function automatic coef_out_t tag_coef(input logic [1:0] comp, input int i, input coef_t v);
        return {comp, pix_idx_t'(i), v};
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("FAIL t=%0t %s", $time, msg);
    endtask

    task automatic run_block(input int t);
        blk4x4_t               lp;
        blk4x4_t               lo;
        blk4x4_t               cbo;
        blk4x4_t               cro;
        chroma_win_t           cbw;
        chroma_win_t           crw;
        mv_frac_t              f_start;
        mv_frac_t              f_used;
        logic [`MC_QSH_W-1:0]  qsh;
        logic [31:0]           v;
        int                    err0;
        err0 = errors;
        rand_block(lp);
        rand_block(lo);
        rand_block(cbo);
        rand_block(cro);
        rand_window(cbw);
        rand_window(crw);
        take_bits(2 * `MC_FRAC_W, v);
        f_start = v[2*`MC_FRAC_W-1:0];
        take_bits(2 * `MC_FRAC_W, v);
        f_used = v[2*`MC_FRAC_W-1:0];
        take_bits(`MC_QSH_W, v);
        qsh = v[`MC_QSH_W-1:0];
        if (t == 0) begin                           // integer position, no shift
            f_used = '0;
            qsh    = '0;
        end else if (t == 1) begin
            f_used = '1;
            qsh    = '1;
        end
        if (f_start == f_used)
            f_start = ~f_used;                      // the window update must matter
        for (int i = 0; i < `MC_BLK_PIX; i++) begin
            exp_coef[i] = tag_coef(COMP_LUMA, i, quantize(lo[i], lp[i], qsh));
            exp_coef[i + 16] = tag_coef(COMP_CB, i,
                quantize(cbo[i], bilinear(cbw, f_used, i % 4, i / 4), qsh));
            exp_coef[i + 32] = tag_coef(COMP_CR, i,
                quantize(cro[i], bilinear(crw, f_used, i % 4, i / 4), qsh));
        end
        @(posedge clk);
        luma_pred <= lp;
        luma_orig <= lo;
        cb_orig   <= cbo;
        cr_orig   <= cro;
        cb_win    <= cbw;
        cr_win    <= crw;
        mv_frac   <= f_start;
        qshift    <= qsh;
        mc_start  <= 1'b1;
        @(posedge clk);
        mc_start <= 1'b0;
        do @(posedge clk); while (!mvd_access);
        mv_frac <= f_used;                          // new fraction during luma phase
        do @(posedge clk); while (!mc_done);
        @(negedge clk);
        if (errors != err0)
            tests_failed++;
        $display("test %0d dx=%0d dy=%0d qshift=%0d: %s", t, f_used.dx, f_used.dy, qsh,
                 (errors == err0) ? "ok" : "mismatch");
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (mc_start) begin
            started    <= 1'b1;
            run_active <= 1'b1;
            run_cyc    <= 1;
            coef_cnt   <= 0;
        end else if (run_active) begin
            run_cyc <= run_cyc + 1;
            if (coef_valid)
                coef_cnt <= coef_cnt + 1;
            if (mc_done)
                run_active <= 1'b0;
        end
    end

    assign exp_now = exp_coef[coef_cnt];

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
        !started |-> (!mc_done && !coef_valid && !mvd_access))
        else report_fail("output active before the first start");

    a_done_time: assert property (@(posedge clk) disable iff (!rstn)
        mc_done == (run_active && run_cyc == RUN_CYC))
        else report_fail($sformatf("mc_done %0b in run cycle %0d",
                                   $sampled(mc_done), $sampled(run_cyc)));

    a_access_window: assert property (@(posedge clk) disable iff (!rstn)
        mvd_access == (run_active && (run_cyc inside {[1:16]})))
        else report_fail($sformatf("mvd_access %0b in run cycle %0d",
                                   $sampled(mvd_access), $sampled(run_cyc)));

    a_valid_bursts: assert property (@(posedge clk) disable iff (!rstn)
        coef_valid == (run_active && (run_cyc inside {[1:16], [33:48], [65:80]})))
        else report_fail($sformatf("coef_valid %0b in run cycle %0d",
                                   $sampled(coef_valid), $sampled(run_cyc)));

    a_coef_value: assert property (@(posedge clk) disable iff (!rstn)
        coef_valid |-> (coef == exp_now))
        else report_fail($sformatf("coef %0d got comp %b idx %0d value %0d, exp %b %0d %0d",
            $sampled(coef_cnt), $sampled(coef.comp), $sampled(coef.idx),
            $sampled(coef.value), $sampled(exp_now.comp), $sampled(exp_now.idx),
            $sampled(exp_now.value)));

    a_coef_count: assert property (@(posedge clk) disable iff (!rstn)
        mc_done |-> coef_cnt == N_COEF)
        else report_fail($sformatf("%0d coefficients in the run", $sampled(coef_cnt)));

    initial begin
        while (cycle_cnt < MAX_CYC) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, the run did not finish within %0d clock cycles", MAX_CYC);
        $display("Verification failed");
        $finish;
    end

    initial begin
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        repeat (3) @(posedge clk);                  // idle outputs must stay low
        for (int t = 0; t < N_TESTS; t++)
            run_block(t);
        $display("%0d tests, %0d passed, %0d failed, %0d check failures",
                 N_TESTS, N_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
mc_pixel_pkg.sv
mc_ctrl_pkg.sv
mc_ctrl.sv
chroma_interp.sv
tq_unit.sv
mc_top.sv
tb_mc_top.sv
